// File: design/soc_bus_pkg.sv
package soc_bus_pkg;

	// ==========================================================
	// Shared bus geometry
	// ==========================================================

	// Word and address width of every bus link
	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;

	// ==========================================================
	// Address map
	// ==========================================================

	// Region codes live in address bits 31 to 28
	localparam logic [3:0] REGION_RAM   = 4'h1;
	localparam logic [3:0] REGION_DMA   = 4'h9;
	localparam logic [3:0] REGION_TIMER = 4'ha;

	// On-chip RAM, 2 KiB
	localparam int RAM_WORDS     = 512;
	localparam int RAM_ADDR_BITS = 9;

endpackage

// File: design/soc_periph_pkg.sv
package soc_periph_pkg;

	// ==========================================================
	// Interval timer register map
	// ==========================================================

	// Word offsets, taken from address bits 3 to 2
	localparam logic [1:0] TIMER_REG_CTRL    = 2'd0;
	localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;
	localparam logic [1:0] TIMER_REG_COUNT   = 2'd2;
	localparam logic [1:0] TIMER_REG_STATUS  = 2'd3;

	// ==========================================================
	// DMA engine register map
	// ==========================================================

	localparam logic [1:0] DMA_REG_SRC   = 2'd0;
	localparam logic [1:0] DMA_REG_DST   = 2'd1;
	localparam logic [1:0] DMA_REG_COUNT = 2'd2;
	localparam logic [1:0] DMA_REG_CTRL  = 2'd3;

	// ==========================================================
	// Control bits
	// ==========================================================

	// Timer counts while set, DMA starts a copy when written with it set
	localparam int CTRL_ENABLE_BIT = 0;

	// Busy flag as seen in a DMA CTRL read
	localparam int DMA_BUSY_BIT = 1;

endpackage

// File: design/bus_access.sv
`timescale 1ns/1ps

module bus_access
(
	input  logic                                clock,
	input  logic                                i_reset,

	// Port A, host
	input  logic                                i_pa_request,
	input  logic                                i_pa_rw,
	input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  i_pa_address,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_pa_wdata,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_pa_rdata,
	output logic                                o_pa_ready,

	// Port B, DMA master
	input  logic                                i_pb_request,
	input  logic                                i_pb_rw,
	input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  i_pb_address,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_pb_wdata,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_pb_rdata,
	output logic                                o_pb_ready,

	// Shared bus
	output logic                                o_bus_request,
	output logic                                o_bus_rw,
	output logic [soc_bus_pkg::ADDR_WIDTH-1:0]  o_bus_address,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_bus_wdata,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_bus_rdata,
	input  logic                                i_bus_ready
);
	import soc_bus_pkg::*;

	logic                  busy;
	logic                  grant_b;
	logic                  bus_request_q;
	logic                  cmd_rw;
	logic [ADDR_WIDTH-1:0] cmd_address;
	logic [DATA_WIDTH-1:0] cmd_wdata;

	// Idle picks a winner, busy waits one cycle then drives the bus until ready
	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			busy <= 1'b0;
			grant_b <= 1'b0;
			bus_request_q <= 1'b0;
		end
		else if (!busy)
		begin
			if (i_pa_request || i_pb_request)
			begin
				busy <= 1'b1;
				// Host has priority
				grant_b <= !i_pa_request;
			end
		end
		else if (bus_request_q && i_bus_ready)
		begin
			busy <= 1'b0;
			bus_request_q <= 1'b0;
		end
		else
			bus_request_q <= 1'b1;
	end

	// Latch the winning command while idle
	always_ff @(posedge clock)
	begin
		if (!busy)
		begin
			if (i_pa_request)
			begin
				cmd_rw <= i_pa_rw;
				cmd_address <= i_pa_address;
				cmd_wdata <= i_pa_wdata;
			end
			else
			begin
				cmd_rw <= i_pb_rw;
				cmd_address <= i_pb_address;
				cmd_wdata <= i_pb_wdata;
			end
		end
	end

	assign o_bus_request = bus_request_q;
	assign o_bus_rw = cmd_rw;
	assign o_bus_address = cmd_address;
	assign o_bus_wdata = cmd_wdata;

	// Response only goes back to the granted port
	assign o_pa_ready = bus_request_q && i_bus_ready && !grant_b;
	assign o_pb_ready = bus_request_q && i_bus_ready && grant_b;
	assign o_pa_rdata = grant_b ? '0 : i_bus_rdata;
	assign o_pb_rdata = grant_b ? i_bus_rdata : '0;

endmodule

// File: design/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
(
	input  logic                                clock,
	input  logic                                i_reset,

	input  logic                                i_bus_request,
	input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  i_bus_address,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_bus_rdata,
	output logic                                o_bus_ready,

	output logic                                o_ram_request,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_ram_rdata,
	input  logic                                i_ram_ready,

	output logic                                o_timer_request,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_timer_rdata,
	input  logic                                i_timer_ready,

	output logic                                o_dma_request,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_dma_rdata,
	input  logic                                i_dma_ready
);
	import soc_bus_pkg::*;

	logic [3:0] region;
	logic       ram_select;
	logic       timer_select;
	logic       dma_select;
	logic       none_select;
	logic       none_ready;

	assign region = i_bus_address[ADDR_WIDTH-1:ADDR_WIDTH-4];
	assign ram_select = region == REGION_RAM;
	assign timer_select = region == REGION_TIMER;
	assign dma_select = region == REGION_DMA;
	assign none_select = !(ram_select || timer_select || dma_select);

	assign o_ram_request = i_bus_request && ram_select;
	assign o_timer_request = i_bus_request && timer_select;
	assign o_dma_request = i_bus_request && dma_select;

	// Unmapped region, answer after one cycle so the bus never hangs
	always_ff @(posedge clock)
	begin
		if (i_reset)
			none_ready <= 1'b0;
		else
			none_ready <= i_bus_request && none_select && !none_ready;
	end

	// Return mux, reads of unmapped space give zero
	always_comb
	begin
		o_bus_rdata = '0;
		o_bus_ready = none_ready;
		if (ram_select)
		begin
			o_bus_rdata = i_ram_rdata;
			o_bus_ready = i_ram_ready;
		end
		else if (timer_select)
		begin
			o_bus_rdata = i_timer_rdata;
			o_bus_ready = i_timer_ready;
		end
		else if (dma_select)
		begin
			o_bus_rdata = i_dma_rdata;
			o_bus_ready = i_dma_ready;
		end
	end

endmodule

// File: design/block_ram.sv
`timescale 1ns/1ps

module block_ram
(
	input  logic                                  clock,
	input  logic                                  i_request,
	input  logic                                  i_rw,
	input  logic [soc_bus_pkg::RAM_ADDR_BITS-1:0] i_address,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]    i_wdata,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]    o_rdata,
	output logic                                  o_ready
);
	import soc_bus_pkg::*;

	logic [DATA_WIDTH-1:0] mem [RAM_WORDS];
	logic                  accept;

	// Master holds request through the ready cycle, skip it there
	assign accept = i_request && !o_ready;

	always_ff @(posedge clock)
	begin
		o_ready <= accept;
		if (accept)
		begin
			if (i_rw)
				mem[i_address] <= i_wdata;
			else
				o_rdata <= mem[i_address];
		end
	end

endmodule

// File: design/interval_timer.sv
`timescale 1ns/1ps

module interval_timer
(
	input  logic                                clock,
	input  logic                                i_reset,
	input  logic                                i_request,
	input  logic                                i_rw,
	input  logic [1:0]                          i_address,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_wdata,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_rdata,
	output logic                                o_ready,
	output logic                                o_interrupt
);
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	logic [DATA_WIDTH-1:0] ctrl;
	logic [DATA_WIDTH-1:0] compare;
	logic [DATA_WIDTH-1:0] count;
	logic                  status;
	logic                  accept;
	logic                  enable;
	logic                  wrap;

	assign accept = i_request && !o_ready;
	assign enable = ctrl[CTRL_ENABLE_BIT];
	assign wrap = enable && (count == compare);
	assign o_interrupt = status;

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			ctrl <= '0;
			compare <= '0;
			count <= '0;
			status <= 1'b0;
			o_ready <= 1'b0;
		end
		else
		begin
			o_ready <= accept;
			if (wrap)
				count <= '0;
			else if (enable)
				count <= count + 1'b1;
			if (accept && i_rw)
			begin
				case (i_address)
					TIMER_REG_CTRL:    ctrl <= i_wdata;
					TIMER_REG_COMPARE: compare <= i_wdata;
					TIMER_REG_COUNT:   count <= i_wdata;
					TIMER_REG_STATUS:  status <= 1'b0;
				endcase
			end
			// A match in the same cycle as a clear is not lost
			if (wrap)
				status <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept && !i_rw)
		begin
			case (i_address)
				TIMER_REG_CTRL:    o_rdata <= ctrl;
				TIMER_REG_COMPARE: o_rdata <= compare;
				TIMER_REG_COUNT:   o_rdata <= count;
				TIMER_REG_STATUS:  o_rdata <= {{(DATA_WIDTH-1){1'b0}}, status};
			endcase
		end
	end

endmodule

// File: design/dma_engine.sv
`timescale 1ns/1ps

module dma_engine
(
	input  logic                                clock,
	input  logic                                i_reset,

	// Register port
	input  logic                                i_request,
	input  logic                                i_rw,
	input  logic [1:0]                          i_address,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_wdata,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_rdata,
	output logic                                o_ready,

	// Bus master port
	output logic                                o_bus_request,
	output logic                                o_bus_rw,
	output logic [soc_bus_pkg::ADDR_WIDTH-1:0]  o_bus_address,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_bus_wdata,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_bus_rdata,
	input  logic                                i_bus_ready,

	output logic                                o_busy
);
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	logic [ADDR_WIDTH-1:0] src;
	logic [ADDR_WIDTH-1:0] dst;
	logic [DATA_WIDTH-1:0] count;
	logic [DATA_WIDTH-1:0] data;
	logic [DATA_WIDTH-1:0] ctrl_word;
	logic                  busy;
	logic                  phase_write;
	logic                  accept;
	logic                  reg_write;

	assign accept = i_request && !o_ready;
	// Registers are frozen during a copy
	assign reg_write = accept && i_rw && !busy;

	// ==========================================================
	// Register writes and copy sequencing
	// ==========================================================

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			src <= '0;
			dst <= '0;
			count <= '0;
			busy <= 1'b0;
			phase_write <= 1'b0;
			o_ready <= 1'b0;
		end
		else
		begin
			o_ready <= accept;
			if (reg_write)
			begin
				case (i_address)
					DMA_REG_SRC:   src <= i_wdata;
					DMA_REG_DST:   dst <= i_wdata;
					DMA_REG_COUNT: count <= i_wdata;
					DMA_REG_CTRL:
					begin
						// Zero words means nothing to do
						if (i_wdata[CTRL_ENABLE_BIT] && count != '0)
						begin
							busy <= 1'b1;
							phase_write <= 1'b0;
						end
					end
				endcase
			end
			else if (busy && i_bus_ready)
			begin
				if (!phase_write)
					phase_write <= 1'b1;
				else
				begin
					phase_write <= 1'b0;
					src <= src + ADDR_WIDTH'(4);
					dst <= dst + ADDR_WIDTH'(4);
					count <= count - 1'b1;
					if (count == DATA_WIDTH'(1))
						busy <= 1'b0;
				end
			end
		end
	end

	// Word in flight between the read and the write
	always_ff @(posedge clock)
	begin
		if (busy && !phase_write && i_bus_ready)
			data <= i_bus_rdata;
	end

	// ==========================================================
	// Register reads
	// ==========================================================

	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[DMA_BUSY_BIT] = busy;
	end

	always_ff @(posedge clock)
	begin
		if (accept && !i_rw)
		begin
			case (i_address)
				DMA_REG_SRC:   o_rdata <= src;
				DMA_REG_DST:   o_rdata <= dst;
				DMA_REG_COUNT: o_rdata <= count;
				DMA_REG_CTRL:  o_rdata <= ctrl_word;
			endcase
		end
	end

	assign o_bus_request = busy;
	assign o_bus_rw = phase_write;
	assign o_bus_address = phase_write ? dst : src;
	assign o_bus_wdata = data;
	assign o_busy = busy;

endmodule

// File: design/soc_fabric.sv
`timescale 1ns/1ps

module soc_fabric
(
	input  logic                                clock,
	input  logic                                i_reset,

	input  logic                                i_host_request,
	input  logic                                i_host_rw,
	input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  i_host_address,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_host_wdata,
	output logic [soc_bus_pkg::DATA_WIDTH-1:0]  o_host_rdata,
	output logic                                o_host_ready,

	output logic                                o_timer_interrupt,
	output logic                                o_dma_busy
);
	import soc_bus_pkg::*;

	// Shared bus
	logic                  bus_request;
	logic                  bus_rw;
	logic [ADDR_WIDTH-1:0] bus_address;
	logic [DATA_WIDTH-1:0] bus_wdata;
	logic [DATA_WIDTH-1:0] bus_rdata;
	logic                  bus_ready;

	// DMA master side
	logic                  dma_bus_request;
	logic                  dma_bus_rw;
	logic [ADDR_WIDTH-1:0] dma_bus_address;
	logic [DATA_WIDTH-1:0] dma_bus_wdata;
	logic [DATA_WIDTH-1:0] dma_bus_rdata;
	logic                  dma_bus_ready;

	// Target side
	logic                  ram_request;
	logic [DATA_WIDTH-1:0] ram_rdata;
	logic                  ram_ready;
	logic                  timer_request;
	logic [DATA_WIDTH-1:0] timer_rdata;
	logic                  timer_ready;
	logic                  dma_request;
	logic [DATA_WIDTH-1:0] dma_rdata;
	logic                  dma_ready;

	// ==========================================================
	// Arbiter and decoder
	// ==========================================================

	bus_access u_bus_access
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_pa_request(i_host_request),
		.i_pa_rw(i_host_rw),
		.i_pa_address(i_host_address),
		.i_pa_wdata(i_host_wdata),
		.o_pa_rdata(o_host_rdata),
		.o_pa_ready(o_host_ready),
		.i_pb_request(dma_bus_request),
		.i_pb_rw(dma_bus_rw),
		.i_pb_address(dma_bus_address),
		.i_pb_wdata(dma_bus_wdata),
		.o_pb_rdata(dma_bus_rdata),
		.o_pb_ready(dma_bus_ready),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_rdata(bus_rdata),
		.i_bus_ready(bus_ready)
	);

	bus_decoder u_bus_decoder
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.o_bus_rdata(bus_rdata),
		.o_bus_ready(bus_ready),
		.o_ram_request(ram_request),
		.i_ram_rdata(ram_rdata),
		.i_ram_ready(ram_ready),
		.o_timer_request(timer_request),
		.i_timer_rdata(timer_rdata),
		.i_timer_ready(timer_ready),
		.o_dma_request(dma_request),
		.i_dma_rdata(dma_rdata),
		.i_dma_ready(dma_ready)
	);

	// ==========================================================
	// Targets
	// ==========================================================

	// Byte address to word index
	block_ram u_block_ram
	(
		.clock(clock),
		.i_request(ram_request),
		.i_rw(bus_rw),
		.i_address(bus_address[RAM_ADDR_BITS+1:2]),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	interval_timer u_interval_timer
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(timer_request),
		.i_rw(bus_rw),
		.i_address(bus_address[3:2]),
		.i_wdata(bus_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_interrupt(o_timer_interrupt)
	);

	dma_engine u_dma_engine
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(dma_request),
		.i_rw(bus_rw),
		.i_address(bus_address[3:2]),
		.i_wdata(bus_wdata),
		.o_rdata(dma_rdata),
		.o_ready(dma_ready),
		.o_bus_request(dma_bus_request),
		.o_bus_rw(dma_bus_rw),
		.o_bus_address(dma_bus_address),
		.o_bus_wdata(dma_bus_wdata),
		.i_bus_rdata(dma_bus_rdata),
		.i_bus_ready(dma_bus_ready),
		.o_busy(o_dma_busy)
	);

endmodule

// File: testbench/soc_checker.sv
`timescale 1ns/1ps

module soc_checker
(
	input  logic                                clock,
	input  logic                                i_reset,
	input  logic [7:0]                          i_test_id,
	input  logic                                i_host_rw,
	input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  i_host_address,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_host_wdata,
	input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  i_host_rdata,
	input  logic                                i_host_ready,
	input  logic                                i_timer_interrupt,
	input  logic                                i_dma_busy,
	output int                                  o_mismatches,
	output int                                  o_errors
);
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	// ==========================================================
	// Reference model state
	// ==========================================================

	logic [DATA_WIDTH-1:0] model_ram [RAM_WORDS];
	logic [DATA_WIDTH-1:0] timer_ctrl;
	logic [DATA_WIDTH-1:0] timer_compare;
	logic [ADDR_WIDTH-1:0] dma_src;
	logic [ADDR_WIDTH-1:0] dma_dst;
	logic [DATA_WIDTH-1:0] dma_count;
	logic                  busy_q;
	logic                  irq_q;
	logic                  status_clear;
	logic [DATA_WIDTH-1:0] expected;

	initial
	begin
		o_mismatches = 0;
		o_errors = 0;
		timer_ctrl = '0;
		timer_compare = '0;
		dma_src = '0;
		dma_dst = '0;
		dma_count = '0;
	end

	function automatic string test_name(input logic [7:0] id);
		case (id)
			8'd1:    return "ram_write_read";
			8'd2:    return "unmapped_region";
			8'd3:    return "timer";
			8'd4:    return "dma_copy";
			8'd5:    return "contention";
			default: return "idle";
		endcase
	endfunction

	// Registers whose value moves on its own are not compared
	function automatic logic is_checked(input logic [ADDR_WIDTH-1:0] addr);
		if (addr[31:28] == REGION_TIMER)
			return addr[3:2] != TIMER_REG_COUNT;
		if (addr[31:28] == REGION_DMA)
			return addr[3:2] == DMA_REG_CTRL;
		return 1'b1;
	endfunction

	// Expected host read value for any address
	function automatic logic [DATA_WIDTH-1:0] expected_read(input logic [ADDR_WIDTH-1:0] addr);
		logic [DATA_WIDTH-1:0] value;
		value = '0;
		if (addr[31:28] == REGION_RAM)
			value = model_ram[addr[RAM_ADDR_BITS+1:2]];
		else if (addr[31:28] == REGION_TIMER)
		begin
			if (addr[3:2] == TIMER_REG_CTRL)
				value = timer_ctrl;
			else if (addr[3:2] == TIMER_REG_COMPARE)
				value = timer_compare;
			else if (addr[3:2] == TIMER_REG_STATUS)
				value[0] = irq_q;
		end
		else if (addr[31:28] == REGION_DMA && addr[3:2] == DMA_REG_CTRL)
			value[DMA_BUSY_BIT] = busy_q;
		return value;
	endfunction

	task automatic record_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
		if (addr[31:28] == REGION_RAM)
			model_ram[addr[RAM_ADDR_BITS+1:2]] = data;
		else if (addr[31:28] == REGION_TIMER)
		begin
			if (addr[3:2] == TIMER_REG_CTRL)
				timer_ctrl = data;
			else if (addr[3:2] == TIMER_REG_COMPARE)
				timer_compare = data;
		end
		else if (addr[31:28] == REGION_DMA && !busy_q)
		begin
			if (addr[3:2] == DMA_REG_SRC)
				dma_src = data;
			else if (addr[3:2] == DMA_REG_DST)
				dma_dst = data;
			else if (addr[3:2] == DMA_REG_COUNT)
				dma_count = data;
			else if (data[CTRL_ENABLE_BIT] && dma_count != '0 && !i_dma_busy)
			begin
				// Busy is already up when the start write completes
				$display("ERROR: DMA copy did not start after a CTRL write in test %s",
					test_name(i_test_id));
				o_errors = o_errors + 1;
			end
		end
	endtask

	// Whole copy lands in the model once busy falls
	task automatic apply_copy();
		logic [RAM_ADDR_BITS-1:0] s;
		logic [RAM_ADDR_BITS-1:0] d;
		s = dma_src[RAM_ADDR_BITS+1:2];
		d = dma_dst[RAM_ADDR_BITS+1:2];
		for (int i = 0; i < int'(dma_count); i++)
		begin
			model_ram[d] = model_ram[s];
			s = s + 1'b1;
			d = d + 1'b1;
		end
	endtask

	// ==========================================================
	// Compare process
	// ==========================================================

	assign status_clear = i_host_ready && i_host_rw && i_host_address[31:28] == REGION_TIMER
		&& i_host_address[3:2] == TIMER_REG_STATUS;

	always @(posedge clock)
	begin
		if (i_reset)
		begin
			busy_q <= 1'b0;
			irq_q <= 1'b0;
		end
		else
		begin
			if (i_host_ready && i_host_rw)
				record_write(i_host_address, i_host_wdata);
			else if (i_host_ready && is_checked(i_host_address))
			begin
				expected = expected_read(i_host_address);
				if (expected !== i_host_rdata)
				begin
					$display("MISMATCH test=%s address=%h expected=%h actual=%h",
						test_name(i_test_id), i_host_address, expected, i_host_rdata);
					o_mismatches = o_mismatches + 1;
				end
			end
			if (irq_q && !i_timer_interrupt && !status_clear)
			begin
				$display("ERROR: timer interrupt dropped without a status write in test %s",
					test_name(i_test_id));
				o_errors = o_errors + 1;
			end
			if (busy_q && !i_dma_busy)
				apply_copy();
			busy_q <= i_dma_busy;
			irq_q <= i_timer_interrupt;
		end
	end

endmodule

// File: testbench/tb_soc_fabric.sv
`timescale 1ns/1ps

module tb_soc_fabric;
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	// Host access with the DMA idle
	localparam int HOST_LATENCY = 3;
	// About 400 host accesses plus two 16 word copies, at most ~10 cycles each, with margin
	localparam int MAX_CYCLES = 20000;
	localparam int COPY_WORDS = 16;

	logic                  clock;
	logic                  i_reset;
	logic                  i_host_request;
	logic                  i_host_rw;
	logic [ADDR_WIDTH-1:0] i_host_address;
	logic [DATA_WIDTH-1:0] i_host_wdata;
	logic [DATA_WIDTH-1:0] o_host_rdata;
	logic                  o_host_ready;
	logic                  o_timer_interrupt;
	logic                  o_dma_busy;

	logic [7:0]            test_id;
	logic [8:0]            written [32];
	logic [DATA_WIDTH-1:0] rdata;
	int                    seed;
	int                    errors;
	int                    mismatches;
	int                    checker_errors;
	int                    cycle_count = 0;

	soc_fabric u_soc_fabric
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_host_request(i_host_request),
		.i_host_rw(i_host_rw),
		.i_host_address(i_host_address),
		.i_host_wdata(i_host_wdata),
		.o_host_rdata(o_host_rdata),
		.o_host_ready(o_host_ready),
		.o_timer_interrupt(o_timer_interrupt),
		.o_dma_busy(o_dma_busy)
	);

	soc_checker u_soc_checker
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_test_id(test_id),
		.i_host_rw(i_host_rw),
		.i_host_address(i_host_address),
		.i_host_wdata(i_host_wdata),
		.i_host_rdata(o_host_rdata),
		.i_host_ready(o_host_ready),
		.i_timer_interrupt(o_timer_interrupt),
		.i_dma_busy(o_dma_busy),
		.o_mismatches(mismatches),
		.o_errors(checker_errors)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("ERROR: simulation did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [ADDR_WIDTH-1:0] ram_addr(input int idx);
		return {REGION_RAM, 17'd0, 9'(idx), 2'b00};
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] reg_addr(input logic [3:0] region, input logic [1:0] r);
		return {region, 24'd0, r, 2'b00};
	endfunction

	// ==========================================================
	// Host port handshake
	// ==========================================================

	task automatic host_access(input logic rw, input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] wdata, input logic check_latency,
		output logic [DATA_WIDTH-1:0] result);
		int cycles;
		@(posedge clock);
		i_host_request <= 1'b1;
		i_host_rw <= rw;
		i_host_address <= addr;
		i_host_wdata <= wdata;
		cycles = 0;
		do
		begin
			@(posedge clock);
			cycles++;
		end
		while (!o_host_ready);
		result = o_host_rdata;
		i_host_request <= 1'b0;
		// Ready is seen on the edge after it rises
		if (check_latency && cycles != HOST_LATENCY + 1)
		begin
			$display("ERROR: host ready came %0d cycles after request at %h, expected %0d",
				cycles - 1, addr, HOST_LATENCY);
			errors++;
		end
	endtask

	task automatic host_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
		logic [DATA_WIDTH-1:0] unused;
		host_access(1'b1, addr, data, 1'b1, unused);
	endtask

	task automatic host_read(input logic [ADDR_WIDTH-1:0] addr, input logic check_latency);
		host_access(1'b0, addr, '0, check_latency, rdata);
	endtask

	task automatic fill_ram(input int first, input int words);
		for (int i = 0; i < words; i++)
			host_write(ram_addr(first + i), $random(seed));
	endtask

	task automatic read_range(input int first, input int words);
		for (int i = 0; i < words; i++)
			host_read(ram_addr(first + i), 1'b1);
	endtask

	task automatic dma_start(input int src, input int dst, input int words);
		host_write(reg_addr(REGION_DMA, DMA_REG_SRC), ram_addr(src));
		host_write(reg_addr(REGION_DMA, DMA_REG_DST), ram_addr(dst));
		host_write(reg_addr(REGION_DMA, DMA_REG_COUNT), DATA_WIDTH'(words));
		host_write(reg_addr(REGION_DMA, DMA_REG_CTRL), DATA_WIDTH'(1) << CTRL_ENABLE_BIT);
	endtask

	// Poll CTRL until the busy flag clears
	task automatic dma_wait();
		do
			host_read(reg_addr(REGION_DMA, DMA_REG_CTRL), 1'b0);
		while (rdata[DMA_BUSY_BIT]);
		if (o_dma_busy)
		begin
			$display("ERROR: DMA busy output still high after CTRL reported idle");
			errors++;
		end
	endtask

	// ==========================================================
	// Tests
	// ==========================================================

	task automatic ram_test();
		test_id = 8'd1;
		for (int i = 0; i < 32; i++)
		begin
			written[i] = 9'($random(seed) & 127);
			host_write(ram_addr(int'(written[i])), $random(seed));
		end
		for (int i = 0; i < 32; i++)
			host_read(ram_addr(int'(written[i])), 1'b1);
	endtask

	task automatic unmapped_test();
		logic [ADDR_WIDTH-1:0] addr;
		test_id = 8'd2;
		addr = {4'h5, 17'd0, written[0], 2'b00};
		host_read(addr, 1'b1);
		host_write(addr, $random(seed));
		host_read(ram_addr(int'(written[0])), 1'b1);
	endtask

	task automatic timer_test();
		int waited;
		test_id = 8'd3;
		host_write(reg_addr(REGION_TIMER, TIMER_REG_COMPARE), 32'd20);
		host_write(reg_addr(REGION_TIMER, TIMER_REG_CTRL), DATA_WIDTH'(1) << CTRL_ENABLE_BIT);
		host_read(reg_addr(REGION_TIMER, TIMER_REG_COMPARE), 1'b1);
		host_read(reg_addr(REGION_TIMER, TIMER_REG_CTRL), 1'b1);
		waited = 0;
		while (!o_timer_interrupt && waited < 200)
		begin
			@(posedge clock);
			waited++;
		end
		if (!o_timer_interrupt)
		begin
			$display("ERROR: timer interrupt never rose");
			errors++;
		end
		host_read(reg_addr(REGION_TIMER, TIMER_REG_STATUS), 1'b1);
		repeat (10) @(posedge clock);
		// Stop counting so the flag cannot set again
		host_write(reg_addr(REGION_TIMER, TIMER_REG_CTRL), '0);
		host_write(reg_addr(REGION_TIMER, TIMER_REG_STATUS), '0);
		if (o_timer_interrupt)
		begin
			$display("ERROR: timer interrupt still high after status write");
			errors++;
		end
		host_read(reg_addr(REGION_TIMER, TIMER_REG_STATUS), 1'b1);
	endtask

	task automatic dma_test();
		test_id = 8'd4;
		fill_ram(256, COPY_WORDS);
		dma_start(256, 320, COPY_WORDS);
		dma_wait();
		read_range(320, COPY_WORDS);
		read_range(256, COPY_WORDS);
	endtask

	task automatic contention_test();
		test_id = 8'd5;
		fill_ram(128, COPY_WORDS);
		dma_start(128, 448, COPY_WORDS);
		for (int i = 0; i < 24; i++)
		begin
			host_access(1'b1, ram_addr(384 + i), $random(seed), 1'b0, rdata);
			host_read(ram_addr(384 + i), 1'b0);
			host_read(ram_addr(384 + i / 2), 1'b0);
		end
		dma_wait();
		read_range(448, COPY_WORDS);
		read_range(128, COPY_WORDS);
	endtask

	initial
	begin
		seed = 58;
		errors = 0;
		test_id = 8'd0;
		i_reset = 1'b1;
		i_host_request = 1'b0;
		i_host_rw = 1'b0;
		i_host_address = '0;
		i_host_wdata = '0;
		rdata = '0;
		repeat (4) @(posedge clock);
		i_reset <= 1'b0;

		ram_test();
		unmapped_test();
		timer_test();
		dma_test();
		contention_test();

		repeat (4) @(posedge clock);
		$display("Done: %0d mismatches, %0d other errors", mismatches, errors + checker_errors);
		if (mismatches == 0 && errors == 0 && checker_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: build.f
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/bus_access.sv
design/bus_decoder.sv
design/block_ram.sv
design/interval_timer.sv
design/dma_engine.sv
design/soc_fabric.sv
testbench/soc_checker.sv
testbench/tb_soc_fabric.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_soc_fabric -o sim_soc_fabric

./obj_dir/sim_soc_fabric | tee sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
